//--- common/burst_pkg.sv
// burst uncompressor shared definitions
`default_nettype none

package burst_pkg;

   // ------------------------------------------------------------------------
   // beat state
   // ------------------------------------------------------------------------

   // idle means the next sink item starts a new burst
   // busy means the second or a later beat of a compressed burst is pending
   typedef enum logic {
      beat_idle = 1'b0,
      beat_busy = 1'b1
   } beat_state_e;

   // ------------------------------------------------------------------------
   // default widths of the top level
   // ------------------------------------------------------------------------

   localparam int default_addr_w      = 16;
   localparam int default_burstwrap_w = 3;
   localparam int default_byte_cnt_w  = 4;
   localparam int default_pkt_symbols = 4;
   localparam int default_burst_size_w = 3;

   // the widest address the size decode can serve
   localparam int max_addr_w = 64;

   // ------------------------------------------------------------------------
   // transfer size decode
   // ------------------------------------------------------------------------

   // turns a burst size encoding into the number of bytes moved per beat
   // only encodings 0 to 9 are defined and anything above falls back to one byte
   // the caller keeps the low address-width bits of the result
   function automatic logic [max_addr_w-1:0] size_to_bytes(input int unsigned enc);
      logic [max_addr_w-1:0] step;
      step = max_addr_w'(1);
      if (enc <= 9) begin
         step = max_addr_w'(1) << enc;
      end
      return step;
   endfunction

endpackage

`default_nettype wire

//--- common/beat_ctrl_if.sv
// per-beat control bundle
`timescale 1ns/10ps
`default_nettype none

interface beat_ctrl_if;

   // high while a valid sink item is presented and no burst is in progress
   logic first_beat;

   // high in any cycle where the source beat is taken
   logic advance;

   // high on the beat that retires the sink item
   // an uncompressed item is always its own last beat
   logic last_beat;

   // high when the byte count shown on the source equals one beat of symbols
   logic final_count;

   // the control FSM produces the strobes and watches the count
   modport ctrl (
      output first_beat,
      output advance,
      output last_beat,
      input  final_count
   );

   // the byte counter follows the strobes and reports the final beat
   modport counter (
      input  first_beat,
      input  advance,
      input  last_beat,
      output final_count
   );

   // the address generator only needs to know where a burst starts and steps
   modport addr (
      input first_beat,
      input advance
   );

endinterface

`default_nettype wire

//--- rtl/burst_control.sv
// beat state machine and delimiters
`timescale 1ns/10ps
`default_nettype none

module burst_control (
   input  wire logic  clk,
   input  wire logic  reset,
   input  wire logic  sink_valid,
   input  wire logic  sink_startofpacket,
   input  wire logic  sink_endofpacket,
   input  wire logic  sink_is_compressed,
   input  wire logic  source_ready,
   output logic       source_valid,
   output logic       source_startofpacket,
   output logic       source_endofpacket,
   output logic       sink_ready,
   beat_ctrl_if.ctrl  beat
);

   import burst_pkg::*;

   beat_state_e state;

   // ------------------------------------------------------------------------
   // beat strobes
   // ------------------------------------------------------------------------

   // every sink cycle produces a source beat with no added latency
   assign source_valid = sink_valid;

   // a first beat is any valid item seen while no burst is running
   assign beat.first_beat = sink_valid & (state == beat_idle);

   // the beat is taken when both sides of the source handshake agree
   assign beat.advance = sink_valid & source_ready;

   // uncompressed items always close on their only beat
   // compressed ones close when the shown count is one beat of symbols
   assign beat.last_beat = ~sink_is_compressed | beat.final_count;

   // ------------------------------------------------------------------------
   // packet delimiters and sink handshake
   // ------------------------------------------------------------------------

   // start of packet belongs to the first beat only
   assign source_startofpacket = sink_startofpacket & (state == beat_idle);

   // end of packet belongs to the last beat only, and only if the item had one
   assign source_endofpacket = sink_endofpacket & beat.last_beat;

   // the sink item is retired together with its last accepted beat
   assign sink_ready = beat.advance & beat.last_beat;

   // ------------------------------------------------------------------------
   // state register
   // ------------------------------------------------------------------------

   // nothing moves while the source holds back ready
   // a taken last beat always returns to idle, whatever the state was
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= beat_idle;
      end else if (beat.advance) begin
         if (beat.last_beat) begin
            state <= beat_idle;
         end else begin
            state <= beat_busy;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/burst_byte_counter.sv
// remaining byte counter
`timescale 1ns/10ps
`default_nettype none

module burst_byte_counter #(
   parameter int byte_cnt_w  = 4,
   parameter int pkt_symbols = 4
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic [byte_cnt_w-1:0] sink_byte_cnt,
   output logic [byte_cnt_w-1:0]      source_byte_cnt,
   beat_ctrl_if.counter               beat
);

   // bytes carried by one source beat, sized to the count field
   localparam logic [byte_cnt_w-1:0] beat_bytes = byte_cnt_w'(pkt_symbols);

   // count still to be shown on the next beat of the running burst
   logic [byte_cnt_w-1:0] remaining;

   // ------------------------------------------------------------------------
   // shown count
   // ------------------------------------------------------------------------

   // on the first beat the register is not loaded yet
   // so the sink count goes straight to the source
   assign source_byte_cnt = beat.first_beat ? sink_byte_cnt : remaining;

   // the final beat is the one that still carries exactly one beat of bytes
   assign beat.final_count = (source_byte_cnt == beat_bytes);

   // ------------------------------------------------------------------------
   // counter register
   // ------------------------------------------------------------------------

   // busy always begins with a loaded counter
   // so a later beat only ever steps down from the register
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         remaining <= '0;
      end else if (beat.advance) begin
         if (beat.last_beat) begin
            remaining <= '0;
         end else if (beat.first_beat) begin
            remaining <= sink_byte_cnt - beat_bytes;
         end else begin
            remaining <= remaining - beat_bytes;
         end
      end
   end

endmodule

`default_nettype wire

//--- rtl/addr_gen/burst_addr_gen.sv
// wrapping beat address generator
`timescale 1ns/10ps
`default_nettype none

module burst_addr_gen #(
   parameter int addr_w       = 16,
   parameter int burstwrap_w  = 3,
   parameter int burst_size_w = 3
) (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic [addr_w-1:0]       sink_addr,
   input  wire logic [burstwrap_w-1:0]  sink_burstwrap,
   input  wire logic [burst_size_w-1:0] sink_burstsize,
   output logic [addr_w-1:0]            source_addr,
   beat_ctrl_if.addr                    beat
);

   import burst_pkg::*;

   // burstwrap widened to the address, used as the in-window mask
   logic [addr_w-1:0] wrap_mask;

   // decoded transfer size, full and trimmed to the address
   logic [max_addr_w-1:0] step_full;
   logic [addr_w-1:0]     step;

   // upper address bits that stay fixed for the whole burst
   logic [addr_w-1:0] addr_base;

   // lower address bits that walk and wrap inside the window
   logic [addr_w-1:0] addr_offset;
   logic [addr_w-1:0] offset_prev;
   logic [addr_w-1:0] offset_next;

   // ------------------------------------------------------------------------
   // wrap mask
   // ------------------------------------------------------------------------

   // the top burstwrap bit covers every address bit above the field
   // an all-ones wrap therefore means a plain incrementing burst
   generate
      if (addr_w > burstwrap_w) begin : g_wrap_extend
         assign wrap_mask = {{(addr_w - burstwrap_w){sink_burstwrap[burstwrap_w-1]}},
                             sink_burstwrap};
      end else begin : g_wrap_trim
         assign wrap_mask = sink_burstwrap[addr_w-1:0];
      end
   endgenerate

   // ------------------------------------------------------------------------
   // step and next offset
   // ------------------------------------------------------------------------

   assign step_full = size_to_bytes(int'(sink_burstsize));
   assign step      = step_full[addr_w-1:0];

   // the first beat steps from the sink address itself
   // later beats step from the registered offset
   assign offset_prev = beat.first_beat ? sink_addr : addr_offset;

   // carry out of the window is dropped by the mask, which gives the wrap
   assign offset_next = (offset_prev + step) & wrap_mask;

   // ------------------------------------------------------------------------
   // address registers
   // ------------------------------------------------------------------------

   // the base keeps the address bits above the window, taken on the first beat
   always_ff @(posedge clk) begin
      if (beat.first_beat && beat.advance) begin
         addr_base <= sink_addr & ~wrap_mask;
      end
   end

   // the offset follows every taken beat and holds under back-pressure
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         addr_offset <= '0;
      end else if (beat.advance) begin
         addr_offset <= offset_next;
      end
   end

   // ------------------------------------------------------------------------
   // beat address
   // ------------------------------------------------------------------------

   // the first beat shows the sink address while the registers load
   // base and offset never overlap, so an OR joins them
   assign source_addr = beat.first_beat ? sink_addr : (addr_base | addr_offset);

endmodule

`default_nettype wire

//--- rtl/burst_uncompressor.sv
// burst uncompressor top level
`timescale 1ns/10ps
`default_nettype none

module burst_uncompressor #(
   parameter int addr_w       = burst_pkg::default_addr_w,
   parameter int burstwrap_w  = burst_pkg::default_burstwrap_w,
   parameter int byte_cnt_w   = burst_pkg::default_byte_cnt_w,
   parameter int pkt_symbols  = burst_pkg::default_pkt_symbols,
   parameter int burst_size_w = burst_pkg::default_burst_size_w
) (
   input  wire logic                    clk,
   input  wire logic                    reset,

   // sink side, one item per compressed burst
   input  wire logic                    sink_valid,
   input  wire logic                    sink_startofpacket,
   input  wire logic                    sink_endofpacket,
   input  wire logic [addr_w-1:0]       sink_addr,
   input  wire logic [burstwrap_w-1:0]  sink_burstwrap,
   input  wire logic [byte_cnt_w-1:0]   sink_byte_cnt,
   input  wire logic                    sink_is_compressed,
   input  wire logic [burst_size_w-1:0] sink_burstsize,
   output logic                         sink_ready,

   // source side, one beat per pkt_symbols bytes
   output logic                         source_valid,
   output logic                         source_startofpacket,
   output logic                         source_endofpacket,
   output logic [addr_w-1:0]            source_addr,
   output logic [byte_cnt_w-1:0]        source_byte_cnt,
   input  wire logic                    source_ready
);

   // ------------------------------------------------------------------------
   // shared beat strobes
   // ------------------------------------------------------------------------

   // the control FSM decides first, advance and last for every beat
   // and the byte counter tells it when the final beat is shown
   beat_ctrl_if i_beat_ctrl ();

   // ------------------------------------------------------------------------
   // beat control
   // ------------------------------------------------------------------------

   // handshake and packet delimiters live here
   // the sink item is held by the upstream side until sink_ready pulses
   burst_control i_control (
      .clk                  (clk),
      .reset                (reset),
      .sink_valid           (sink_valid),
      .sink_startofpacket   (sink_startofpacket),
      .sink_endofpacket     (sink_endofpacket),
      .sink_is_compressed   (sink_is_compressed),
      .source_ready         (source_ready),
      .source_valid         (source_valid),
      .source_startofpacket (source_startofpacket),
      .source_endofpacket   (source_endofpacket),
      .sink_ready           (sink_ready),
      .beat                 (i_beat_ctrl.ctrl)
   );

   // ------------------------------------------------------------------------
   // datapath
   // ------------------------------------------------------------------------

   // remaining byte count falls by pkt_symbols on every beat
   burst_byte_counter #(
      .byte_cnt_w  (byte_cnt_w),
      .pkt_symbols (pkt_symbols)
   ) i_byte_counter (
      .clk             (clk),
      .reset           (reset),
      .sink_byte_cnt   (sink_byte_cnt),
      .source_byte_cnt (source_byte_cnt),
      .beat            (i_beat_ctrl.counter)
   );

   // beat address steps by the transfer size inside the wrap window
   burst_addr_gen #(
      .addr_w       (addr_w),
      .burstwrap_w  (burstwrap_w),
      .burst_size_w (burst_size_w)
   ) i_addr_gen (
      .clk            (clk),
      .reset          (reset),
      .sink_addr      (sink_addr),
      .sink_burstwrap (sink_burstwrap),
      .sink_burstsize (sink_burstsize),
      .source_addr    (source_addr),
      .beat           (i_beat_ctrl.addr)
   );

endmodule

`default_nettype wire

//--- bench/tb_burst_model.svh
// expected beat model
`ifndef tb_burst_model_svh
`define tb_burst_model_svh

// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
// the new bit enters at the bottom, so bit 0 is the freshly made one
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

// the wrap field widened to the address by repeating its top bit
function automatic logic [addr_w-1:0] window_mask(input logic [burstwrap_w-1:0] wrap);
   logic [addr_w-1:0] mask;
   int i;
   for (i = 0; i < addr_w; i++) begin
      mask[i] = (i < burstwrap_w) ? wrap[i] : wrap[burstwrap_w-1];
   end
   return mask;
endfunction

// bytes per transfer are 2 to the power of the size code, and 1 above code 9
function automatic logic [addr_w-1:0] size_step(input logic [burst_size_w-1:0] size);
   logic [addr_w-1:0] step;
   step = addr_w'(1);
   if (int'(size) <= 9) begin
      step = step << size;
   end
   return step;
endfunction

// beat k shows the base joined with an offset that walks and wraps from the sink address
function automatic logic [addr_w-1:0] beat_addr(input logic [addr_w-1:0] addr,
                                                input logic [burstwrap_w-1:0] wrap,
                                                input logic [burst_size_w-1:0] size,
                                                input int k);
   logic [addr_w-1:0] mask;
   logic [addr_w-1:0] offset;
   int j;
   mask = window_mask(wrap);
   offset = addr;
   if (k == 0) begin
      return addr;
   end
   for (j = 1; j <= k; j++) begin
      offset = (offset + size_step(size)) & mask;
   end
   return (addr & ~mask) | offset;
endfunction

// each beat carries pkt_symbols bytes fewer than the one before it
function automatic logic [byte_cnt_w-1:0] beat_cnt(input logic [byte_cnt_w-1:0] bcnt,
                                                   input int k);
   return byte_cnt_w'(int'(bcnt) - k * pkt_symbols);
endfunction

`endif

//--- bench/tb_burst_uncompressor.sv
// burst uncompressor testbench
`timescale 1ns/10ps
`default_nettype none

module tb_burst_uncompressor;

   // ------------------------------------------------------------------------
   // configuration
   // ------------------------------------------------------------------------

   // wider wrap and count fields than the defaults so bursts can run longer
   localparam int addr_w       = 16;
   localparam int burstwrap_w  = 8;
   localparam int byte_cnt_w   = 8;
   localparam int pkt_symbols  = 4;
   localparam int burst_size_w = 3;
   localparam int clk_period   = 8;
   localparam int all_beats    = 256;

   // cycle budget of reset and the six tests
   // the watchdog allows four times this
   localparam int run_cycles = 4 + 4 + 20 + 12 + 8 + 48 + 24;

   logic clk = 1'b0;
   logic reset;
   logic sink_valid;
   logic sink_startofpacket;
   logic sink_endofpacket;
   logic [addr_w-1:0] sink_addr;
   logic [burstwrap_w-1:0] sink_burstwrap;
   logic [byte_cnt_w-1:0] sink_byte_cnt;
   logic sink_is_compressed;
   logic [burst_size_w-1:0] sink_burstsize;
   logic sink_ready;
   logic source_valid;
   logic source_startofpacket;
   logic source_endofpacket;
   logic [addr_w-1:0] source_addr;
   logic [byte_cnt_w-1:0] source_byte_cnt;
   logic source_ready;

   // expected beat, driven in step with the stimulus
   logic check_en;
   logic [addr_w-1:0] exp_addr;
   logic [byte_cnt_w-1:0] exp_cnt;
   logic exp_sop;
   logic exp_eop;
   logic exp_sink_ready;

   logic [31:0] lfsr_state = 32'hb44b;
   int errors = 0;
   int errors_at_start = 0;
   int tests_done = 0;

   `include "tb_burst_model.svh"

   burst_uncompressor #(
      .addr_w       (addr_w),
      .burstwrap_w  (burstwrap_w),
      .byte_cnt_w   (byte_cnt_w),
      .pkt_symbols  (pkt_symbols),
      .burst_size_w (burst_size_w)
   ) i_dut (
      .clk                  (clk),
      .reset                (reset),
      .sink_valid           (sink_valid),
      .sink_startofpacket   (sink_startofpacket),
      .sink_endofpacket     (sink_endofpacket),
      .sink_addr            (sink_addr),
      .sink_burstwrap       (sink_burstwrap),
      .sink_byte_cnt        (sink_byte_cnt),
      .sink_is_compressed   (sink_is_compressed),
      .sink_burstsize       (sink_burstsize),
      .sink_ready           (sink_ready),
      .source_valid         (source_valid),
      .source_startofpacket (source_startofpacket),
      .source_endofpacket   (source_endofpacket),
      .source_addr          (source_addr),
      .source_byte_cnt      (source_byte_cnt),
      .source_ready         (source_ready)
   );

   always #(clk_period / 2) clk = ~clk;

   // the run may not outlast four times its planned length
   initial begin
      #(run_cycles * 4 * clk_period);
      $display("watchdog expired at %0t, the DUT stopped producing beats", $time);
      $display("test failed");
      $finish;
   end

   // ------------------------------------------------------------------------
   // error reporting
   // ------------------------------------------------------------------------

   task automatic value_error(input string what,
                              input logic [31:0] got,
                              input logic [31:0] want);
      errors = errors + 1;
      $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, want);
   endtask

   task automatic rule_error(input string what);
      errors = errors + 1;
      $display("[ERROR] %0t: %s", $time, what);
   endtask

   // ------------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------------

   // the beat fields follow the expected model whenever a test drives an item
   a_addr: assert property (@(posedge clk) disable iff (reset)
      check_en |-> (source_addr == exp_addr))
      else value_error("source_addr", 32'($sampled(source_addr)), 32'($sampled(exp_addr)));
   a_cnt: assert property (@(posedge clk) disable iff (reset)
      check_en |-> (source_byte_cnt == exp_cnt))
      else value_error("source_byte_cnt", 32'($sampled(source_byte_cnt)),
                       32'($sampled(exp_cnt)));
   a_sop: assert property (@(posedge clk) disable iff (reset)
      check_en |-> (source_startofpacket == exp_sop))
      else value_error("source_startofpacket", 32'($sampled(source_startofpacket)),
                       32'($sampled(exp_sop)));
   a_eop: assert property (@(posedge clk) disable iff (reset)
      check_en |-> (source_endofpacket == exp_eop))
      else value_error("source_endofpacket", 32'($sampled(source_endofpacket)),
                       32'($sampled(exp_eop)));
   a_sink_ready: assert property (@(posedge clk) disable iff (reset)
      check_en |-> (sink_ready == exp_sink_ready))
      else value_error("sink_ready", 32'($sampled(sink_ready)),
                       32'($sampled(exp_sink_ready)));

   // these hold in every cycle, reset included
   a_valid: assert property (@(posedge clk) source_valid == sink_valid)
      else rule_error("source_valid does not follow sink_valid");
   a_idle_ready: assert property (@(posedge clk) !sink_valid |-> !sink_ready)
      else rule_error("sink_ready is high without a valid sink item");
   a_no_eop: assert property (@(posedge clk) disable iff (reset)
      !sink_endofpacket |-> !source_endofpacket)
      else rule_error("end of packet shown for an item that has none");

   // a stalled beat must look the same in the next cycle
   a_hold: assert property (@(posedge clk) disable iff (reset)
      (check_en && $past(check_en) && !$past(source_ready)) |->
      ($stable(source_addr) && $stable(source_byte_cnt) &&
       $stable(source_startofpacket) && $stable(source_endofpacket)))
      else rule_error("source outputs changed while source_ready was low");

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------

   // presents one sink item until its beats are taken, or until limit beats are
   task automatic drive_item(input logic [addr_w-1:0] addr,
                             input logic [burstwrap_w-1:0] wrap,
                             input logic [burst_size_w-1:0] size,
                             input logic [byte_cnt_w-1:0] bcnt,
                             input logic compressed,
                             input logic sop,
                             input logic eop,
                             input logic random_ready,
                             input int limit);
      int beats;
      int k;
      logic rdy;
      beats = compressed ? int'(bcnt) / pkt_symbols : 1;
      k = 0;
      while (k < beats && k < limit) begin
         rdy = 1'b1;
         if (random_ready) begin
            lfsr_state = lfsr_step(lfsr_state);
            rdy = lfsr_state[0];
         end
         sink_valid         <= 1'b1;
         sink_startofpacket <= sop;
         sink_endofpacket   <= eop;
         sink_addr          <= addr;
         sink_burstwrap     <= wrap;
         sink_byte_cnt      <= bcnt;
         sink_is_compressed <= compressed;
         sink_burstsize     <= size;
         source_ready       <= rdy;
         check_en           <= 1'b1;
         exp_addr           <= beat_addr(addr, wrap, size, k);
         exp_cnt            <= beat_cnt(bcnt, k);
         exp_sop            <= sop && (k == 0);
         exp_eop            <= eop && (k == beats - 1);
         exp_sink_ready     <= rdy && (k == beats - 1);
         @(posedge clk);
         if (rdy) begin
            k = k + 1;
         end
      end
   endtask

   // one idle cycle lets the checks of the last beat run before the report
   task automatic finish_test(input string name);
      sink_valid   <= 1'b0;
      source_ready <= 1'b0;
      check_en     <= 1'b0;
      @(posedge clk);
      tests_done = tests_done + 1;
      $display("%0t %s: %0d errors", $time, name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   initial begin
      reset              <= 1'b1;
      sink_valid         <= 1'b0;
      sink_startofpacket <= 1'b0;
      sink_endofpacket   <= 1'b0;
      sink_addr          <= '0;
      sink_burstwrap     <= '0;
      sink_byte_cnt      <= '0;
      sink_is_compressed <= 1'b0;
      sink_burstsize     <= '0;
      source_ready       <= 1'b0;
      check_en           <= 1'b0;
      exp_addr           <= '0;
      exp_cnt            <= '0;
      exp_sop            <= 1'b0;
      exp_eop            <= 1'b0;
      exp_sink_ready     <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      drive_item(16'h0a5c, 8'hff, 3'd2, 8'd4, 1'b1, 1'b1, 1'b1, 1'b0, all_beats);
      finish_test("single beat");

      drive_item(16'h0400, 8'hff, 3'd2, 8'd64, 1'b1, 1'b1, 1'b1, 1'b0, all_beats);
      finish_test("incrementing burst");

      // sixteen byte window entered at its third word
      drive_item(16'h1238, 8'h0f, 3'd2, 8'd32, 1'b1, 1'b1, 1'b1, 1'b0, all_beats);
      finish_test("wrapping burst");

      drive_item(16'h0100, 8'h0f, 3'd2, 8'd4, 1'b0, 1'b1, 1'b0, 1'b0, all_beats);
      drive_item(16'h0104, 8'h0f, 3'd2, 8'd8, 1'b0, 1'b0, 1'b0, 1'b0, all_beats);
      drive_item(16'h0233, 8'h00, 3'd0, 8'd1, 1'b0, 1'b0, 1'b0, 1'b0, all_beats);
      drive_item(16'h0108, 8'h0f, 3'd2, 8'd4, 1'b0, 1'b0, 1'b1, 1'b0, all_beats);
      finish_test("uncompressed items");

      // the first item leaves its packet open
      drive_item(16'h2214, 8'h1f, 3'd2, 8'd32, 1'b1, 1'b1, 1'b0, 1'b1, all_beats);
      drive_item(16'h3004, 8'hff, 3'd1, 8'd20, 1'b1, 1'b0, 1'b1, 1'b1, all_beats);
      drive_item(16'h3100, 8'hff, 3'd2, 8'd4, 1'b0, 1'b1, 1'b1, 1'b1, all_beats);
      finish_test("back-pressure");

      // reset lands while the counter and state still hold a running burst
      drive_item(16'h5000, 8'hff, 3'd2, 8'd32, 1'b1, 1'b1, 1'b1, 1'b0, 3);
      reset        <= 1'b1;
      sink_valid   <= 1'b0;
      source_ready <= 1'b0;
      check_en     <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      drive_item(16'h6010, 8'hff, 3'd2, 8'd12, 1'b1, 1'b1, 1'b1, 1'b0, all_beats);
      finish_test("reset mid-burst");

      // the checks of the closing idle cycle settle before the verdict
      @(negedge clk);
      $display("summary: %0d tests run, %0d errors", tests_done, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+bench
common/burst_pkg.sv
common/beat_ctrl_if.sv
rtl/burst_control.sv
rtl/burst_byte_counter.sv
rtl/addr_gen/burst_addr_gen.sv
rtl/burst_uncompressor.sv
bench/tb_burst_uncompressor.sv

//--- run.sh
#!/bin/sh
# build the burst uncompressor testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f \
   --top-module tb_burst_uncompressor -Mdir obj_dir -o tb_burst_uncompressor
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build stopped with status $status"
   exit 1
fi

output=$(./obj_dir/tb_burst_uncompressor)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation stopped with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
   exit 0
fi
exit 1
